/* list.f */
+incdir+dv
hdl/draw_pkg.sv
hdl/fb_pkg.sv
hdl/draw_line_1d.sv
hdl/draw_circle_fill.sv
hdl/render_rainbow.sv
hdl/framebuffer.sv
hdl/rainbow_top.sv
dv/tb_rainbow.sv

/* run.sh */
#!/bin/sh
# build the rainbow testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tb_rainbow -f list.f \
    && ./obj_dir/Vtb_rainbow | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && exit 0 || exit 1

/* dv/rainbow_model.svh */
// rainbow scene model
// midpoint fill of the eight circles, ordered pixel list and expected picture
`ifndef RAINBOW_MODEL_SVH
`define RAINBOW_MODEL_SVH

typedef struct packed {
    coord_t x;     // column as drawn, may be off canvas
    coord_t y;     // row as drawn
    cidx_t  cidx;  // colour of the circle
} pixel_t;

pixel_t model_pixels[$];        // every pixel in drawing order
cidx_t  model_pic [FB_PIXELS];  // expected framebuffer contents
logic   model_hit [FB_PIXELS];  // pixel reached by some circle

// outer circles get 2 upward, the innermost one is background
function automatic cidx_t circle_colour(input int id);
    if (id == SHAPE_CNT - 1) begin
        return '0;
    end
    return cidx_t'(2 + id);
endfunction

// one span, left to right, clipped only for the picture
function automatic void add_span(input int xl, input int xr, input int row, input cidx_t c);
    pixel_t p;
    int     idx;
    for (int px = xl; px <= xr; px++) begin
        p.x    = coord_t'(px);
        p.y    = coord_t'(row);
        p.cidx = c;
        model_pixels.push_back(p);
        if (px >= 0 && px < FB_WIDTH * SCALE && row >= 0 && row < FB_HEIGHT * SCALE) begin
            idx = (row / SCALE) * FB_WIDTH + px / SCALE;
            model_pic[idx] = c;  // last write wins
            model_hit[idx] = 1'b1;
        end
    end
endfunction

// midpoint circle from the top of the octant, four spans per step
function automatic void add_circle(input int cx, input int cy, input int r, input cidx_t c);
    int xa;
    int ya;
    int err;
    xa  = 0;
    ya  = r;
    err = 1 - r;
    while (xa <= ya) begin
        add_span(cx - xa, cx + xa, cy + ya, c);
        add_span(cx - xa, cx + xa, cy - ya, c);
        add_span(cx - ya, cx + ya, cy + xa, c);
        add_span(cx - ya, cx + ya, cy - xa, c);
        if (err < 0) begin
            err = err + 2 * xa + 3;
        end else begin
            err = err + 2 * (xa - ya) + 5;
            ya  = ya - 1;
        end
        xa = xa + 1;
    end
endfunction

function automatic void build_scene();
    model_pixels.delete();
    for (int i = 0; i < FB_PIXELS; i++) begin
        model_hit[i] = 1'b0;
    end
    for (int id = 0; id < SHAPE_CNT; id++) begin  // largest first
        add_circle(160 * SCALE, 180 * SCALE, (140 - 10 * id) * SCALE, circle_colour(id));
    end
endfunction

`endif

/* dv/tb_rainbow.sv */
// rainbow renderer testbench
// random oe stalls, pixel stream and framebuffer checked against a scene model
`default_nettype none

module tb_rainbow import draw_pkg::*, fb_pkg::*; ();

    localparam int SCALE = 1;       // drawing scale for DUT and model
    localparam int DRV = 2;         // drive delay after the rising edge
    localparam int MARGIN = 20000;  // reset, idle and per-span overhead

    logic   clk, rst, start, oe;
    coord_t rd_x, rd_y;
    coord_t x, y;
    cidx_t  cidx, rd_cidx;
    logic   drawing, done;

    integer seed = 32'hc802_a8c4;  // fixed stimulus seed
    int     err_value = 0;         // wrong values
    int     err_other = 0;         // count, order and timeout trouble
    int     limit = 0;             // timeout in cycles
    int     cycles = 0;

    logic   check_en = 1'b0;       // pixel monitor active
    int     pix_idx = 0;           // next model pixel
    logic   stalled = 1'b0;        // last cycle held a pixel with oe low
    coord_t stall_x, stall_y;
    logic   done_seen = 1'b0;

    `include "rainbow_model.svh"

    rainbow_top #(
        .SCALE (SCALE)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .oe      (oe),
        .rd_x    (rd_x),
        .rd_y    (rd_y),
        .x       (x),
        .y       (y),
        .cidx    (cidx),
        .drawing (drawing),
        .done    (done),
        .rd_cidx (rd_cidx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_coord(input string name, input coord_t exp, input coord_t act);
        if (act !== exp) begin
            err_value++;
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_cidx(input string name, input cidx_t exp, input cidx_t act);
        if (act !== exp) begin
            err_value++;
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_value++;
            $display("ERROR %s expected %b actual %b", name, exp, act);
        end
    endtask

    function automatic logic next_oe();
        return ($random(seed) & 32'sd3) != 0;  // high about 3 cycles in 4
    endfunction

    // pixel stream monitor, outputs settled mid cycle
    always @(negedge clk) begin
        if (check_en) begin
            if (stalled) begin
                check_coord("stall hold x", stall_x, x);
                check_coord("stall hold y", stall_y, y);
                check_flag("stall hold drawing", 1'b1, drawing);
            end
            if (drawing && oe) begin
                if (pix_idx < model_pixels.size()) begin
                    check_coord("pixel x", model_pixels[pix_idx].x, x);
                    check_coord("pixel y", model_pixels[pix_idx].y, y);
                    check_cidx("pixel cidx", model_pixels[pix_idx].cidx, cidx);
                end else begin
                    err_other++;
                    $display("extra pixel (%0d,%0d) drawn beyond the model list", x, y);
                end
                pix_idx++;
            end
            stalled = drawing && !oe;
            stall_x = x;
            stall_y = y;
            if (done && !done_seen && pix_idx != model_pixels.size()) begin
                err_other++;
                $display("done rose after %0d of %0d pixels", pix_idx, model_pixels.size());
            end
            if (done_seen) begin
                check_flag("done held", 1'b1, done);
                check_flag("drawing after done", 1'b0, drawing);
            end
            done_seen = done_seen || done;
        end
    end

    // reset, idle delay, one scene, a stray start, then the sweep
    task automatic run_scene(input string pass_name);
        int delay;
        rst      = 1'b1;
        start    = 1'b0;
        oe       = 1'b0;
        check_en = 1'b0;
        repeat (8) @(posedge clk);
        #DRV;
        rst       = 1'b0;
        pix_idx   = 0;
        stalled   = 1'b0;
        done_seen = 1'b0;
        check_en  = 1'b1;
        delay = 4 + int'($unsigned($random(seed)) % 16);
        repeat (delay) begin
            check_flag({pass_name, " idle drawing"}, 1'b0, drawing);
            check_flag({pass_name, " idle done"}, 1'b0, done);
            @(posedge clk);
            #DRV;
            oe = next_oe();
        end
        start = 1'b1;
        @(posedge clk);
        #DRV;
        start = 1'b0;
        oe = next_oe();
        while (done !== 1'b1) begin
            @(posedge clk);
            #DRV;
            oe = next_oe();
        end
        if (pix_idx != model_pixels.size()) begin
            err_other++;
            $display("%s drew %0d pixels, model has %0d", pass_name, pix_idx,
                     model_pixels.size());
        end
        repeat (3) @(posedge clk);
        #DRV;
        start = 1'b1;  // must be ignored once done
        @(posedge clk);
        #DRV;
        start = 1'b0;
        repeat (40) begin
            @(posedge clk);
            #DRV;
            oe = next_oe();
        end
        sweep_framebuffer(pass_name);
    endtask

    // one address per cycle, data checked a cycle later
    task automatic sweep_framebuffer(input string pass_name);
        int prev;
        prev = -1;
        for (int idx = 0; idx <= FB_PIXELS; idx++) begin
            @(posedge clk);
            #DRV;
            if (prev >= 0 && model_hit[prev]) begin
                check_cidx($sformatf("%s framebuffer (%0d,%0d)", pass_name,
                           prev % FB_WIDTH, prev / FB_WIDTH), model_pic[prev], rd_cidx);
            end
            if (idx < FB_PIXELS) begin
                rd_x = coord_t'(idx % FB_WIDTH);
                rd_y = coord_t'(idx / FB_WIDTH);
            end
            prev = idx;
        end
    endtask

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        oe    = 1'b0;
        rd_x  = '0;
        rd_y  = '0;
        build_scene();
        limit = 4 * model_pixels.size() + 2 * FB_PIXELS + MARGIN;
        $display("model holds %0d pixels, cycle limit %0d", model_pixels.size(), limit);
        run_scene("first run");
        run_scene("rerun after reset");
        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        @(posedge clk);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run still busy after %0d cycles", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/rainbow_top.sv */
// rainbow renderer top level
// scene sequencer writing into the framebuffer, with a framebuffer read port
`default_nettype none

module rainbow_top import draw_pkg::*; #(
    parameter int SCALE = 1  // drawing scale for sequencer and framebuffer
) (
    input  wire logic   clk,      // clock
    input  wire logic   rst,      // sync reset
    input  wire logic   start,    // begin drawing the scene
    input  wire logic   oe,       // output enable, low stalls drawing
    input  wire coord_t rd_x,     // framebuffer read column
    input  wire coord_t rd_y,     // framebuffer read row
    output coord_t      x,        // drawing column
    output coord_t      y,        // drawing row
    output cidx_t       cidx,     // drawing colour
    output logic        drawing,  // x/y/cidx hold a pixel
    output logic        done,     // scene complete
    output cidx_t       rd_cidx   // framebuffer read data
);

    // scene sequencer with circle and span drawers below it
    render_rainbow #(
        .SCALE (SCALE)
    ) u_render (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .oe      (oe),
        .x       (x),
        .y       (y),
        .cidx    (cidx),
        .drawing (drawing),
        .done    (done)
    );

    // every drawn pixel is also a framebuffer write
    framebuffer #(
        .SCALE (SCALE)
    ) u_fb (
        .clk     (clk),
        .we      (drawing),
        .wx      (x),
        .wy      (y),
        .wcidx   (cidx),
        .rd_x    (rd_x),
        .rd_y    (rd_y),
        .rd_cidx (rd_cidx)
    );

endmodule

`default_nettype wire

/* hdl/framebuffer.sv */
// colour-index framebuffer
// clips drawn pixels to the canvas, stores them, registered read port
`default_nettype none

module framebuffer import draw_pkg::*, fb_pkg::*; #(
    parameter int SCALE = 1  // drawing scale, stored at base resolution
) (
    input  wire logic   clk,      // clock
    input  wire logic   we,       // pixel valid
    input  wire coord_t wx,       // pixel column, drawing units
    input  wire coord_t wy,       // pixel row, drawing units
    input  wire cidx_t  wcidx,    // pixel colour
    input  wire coord_t rd_x,     // read column
    input  wire coord_t rd_y,     // read row
    output cidx_t       rd_cidx   // colour one cycle after rd_x/rd_y
);

    // drawing area seen by the shape drawers
    localparam int DRAW_W = FB_WIDTH * SCALE;
    localparam int DRAW_H = FB_HEIGHT * SCALE;

    cidx_t mem [FB_PIXELS];  // no reset, undefined until drawn

    logic     wr_on_canvas;  // write lands on the canvas
    logic     rd_on_canvas;  // read lies on the canvas
    fb_addr_t wr_addr;
    fb_addr_t rd_addr;

    always_comb begin
        wr_on_canvas = (wx >= 0) && (wy >= 0) && (wx < DRAW_W) && (wy < DRAW_H);
        // scaled coordinates fold back onto base pixels
        wr_addr = fb_addr_t'((int'(wy) / SCALE) * FB_WIDTH + int'(wx) / SCALE);
    end

    always_comb begin
        rd_on_canvas = (rd_x >= 0) && (rd_y >= 0)
                    && (rd_x < FB_WIDTH) && (rd_y < FB_HEIGHT);
        rd_addr = fb_addr_t'(int'(rd_y) * FB_WIDTH + int'(rd_x));
    end

    // later writes to a pixel overwrite earlier ones
    always_ff @(posedge clk) begin
        if (we && wr_on_canvas) begin
            mem[wr_addr] <= wcidx;
        end
    end

    always_ff @(posedge clk) begin
        rd_cidx <= rd_on_canvas ? mem[rd_addr] : '0;  // off canvas reads as 0
    end

endmodule

`default_nettype wire

/* hdl/render_rainbow.sv */
// rainbow scene sequencer
// hands eight nested circles to the circle drawer, largest first
`default_nettype none

module render_rainbow import draw_pkg::*; #(
    parameter int SCALE = 1  // drawing scale, 1 gives 320x180
) (
    input  wire logic clk,      // clock
    input  wire logic rst,      // sync reset
    input  wire logic start,    // begin scene, used in IDLE only
    input  wire logic oe,       // output enable, low stalls
    output coord_t    x,        // pixel column
    output coord_t    y,        // pixel row
    output cidx_t     cidx,     // colour of the current circle
    output logic      drawing,  // x/y/cidx hold a pixel
    output logic      done      // scene complete, held until reset
);

    localparam int CENTRE_X = 160;  // bottom middle of the canvas
    localparam int CENTRE_Y = 180;
    localparam int R_OUTER = 140;   // outermost radius
    localparam int R_STEP = 10;     // radius shrink per circle
    localparam int CIDX_FIRST = 2;  // outermost colour

    typedef logic [$clog2(SHAPE_CNT)-1:0] shape_id_t;
    localparam shape_id_t LAST_ID = shape_id_t'(SHAPE_CNT - 1);

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;
    state_t state;

    shape_id_t shape_id;          // circle being drawn
    coord_t    vx0, vy0, vr0;     // circle setup for the drawer
    logic      draw_start;        // circle start pulse
    logic      draw_done;         // circle finished

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            shape_id   <= '0;
            draw_start <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            case (state)
                IDLE: if (start) state <= INIT;
                INIT: begin
                    draw_start <= 1'b1;  // setup registers load this cycle too
                    state      <= DRAW;
                end
                DRAW: begin
                    if (draw_done) begin
                        if (shape_id == LAST_ID) begin
                            state <= DONE;
                        end else begin
                            shape_id <= shape_id + shape_id_t'(1);
                            state    <= INIT;
                        end
                    end
                end
                default: state <= DONE;  // only rst leaves DONE
            endcase
        end
    end

    // circle geometry and colour, stable through DRAW
    always_ff @(posedge clk) begin
        if (state == INIT) begin
            vx0  <= coord_t'(CENTRE_X * SCALE);
            vy0  <= coord_t'(CENTRE_Y * SCALE);
            vr0  <= coord_t'((R_OUTER - R_STEP * int'(shape_id)) * SCALE);
            cidx <= (shape_id == LAST_ID) ? '0  // innermost cut out in background
                  : cidx_t'(CIDX_FIRST + int'(shape_id));
        end
    end

    draw_circle_fill u_circle (
        .clk     (clk),
        .rst     (rst),
        .start   (draw_start),
        .oe      (oe),
        .x0      (vx0),
        .y0      (vy0),
        .r0      (vr0),
        .x       (x),
        .y       (y),
        .drawing (drawing),
        .done    (draw_done)
    );

    always_comb done = (state == DONE);

endmodule

`default_nettype wire

/* hdl/draw_circle_fill.sv */
// filled circle drawer
// midpoint circle walk over one octant, four horizontal spans per step
`default_nettype none

module draw_circle_fill import draw_pkg::*; (
    input  wire logic   clk,      // clock
    input  wire logic   rst,      // sync reset
    input  wire logic   start,    // begin circle, x0/y0/r0 valid
    input  wire logic   oe,       // output enable, low stalls
    input  wire coord_t x0,       // centre column
    input  wire coord_t y0,       // centre row
    input  wire coord_t r0,       // radius
    output coord_t      x,        // pixel column
    output coord_t      y,        // pixel row
    output logic        drawing,  // x/y hold a pixel
    output logic        done      // circle finished, one cycle
);

    // two extra bits so the 2*r terms never wrap
    typedef logic signed [CORDW+1:0] err_t;

    typedef enum logic [2:0] {IDLE, CHECK, LINE, WAIT, STEP} state_t;
    state_t state;

    coord_t     cx, cy;   // latched centre
    coord_t     xa, ya;   // octant point relative to centre
    err_t       err;      // midpoint decision term
    logic [1:0] span_id;  // span within the current step

    logic   lstart;       // span start pulse
    logic   ldone;        // span finished
    coord_t lx0, lx1, ly; // span ends and row

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            lstart <= 1'b0;
            done   <= 1'b0;
        end else begin
            lstart <= 1'b0;
            done   <= 1'b0;
            case (state)
                IDLE: if (start) state <= CHECK;
                CHECK: begin
                    if (xa > ya) begin  // x has passed y, octant covered
                        done  <= 1'b1;
                        state <= IDLE;
                    end else begin
                        state <= LINE;
                    end
                end
                LINE: begin
                    lstart <= 1'b1;  // span registers load alongside
                    state  <= WAIT;
                end
                WAIT: if (ldone) state <= (span_id == 2'd3) ? STEP : LINE;
                STEP: state <= CHECK;
                default: state <= IDLE;
            endcase
        end
    end

    // walk position, error term and span setup
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    cx  <= x0;
                    cy  <= y0;
                    xa  <= '0;  // start at the top of the octant
                    ya  <= r0;
                    err <= err_t'(1) - err_t'(r0);
                end
            end
            CHECK: span_id <= '0;
            LINE: begin
                case (span_id)
                    2'd0: begin  // lower row, narrow
                        lx0 <= cx - xa;
                        lx1 <= cx + xa;
                        ly  <= cy + ya;
                    end
                    2'd1: begin  // upper row, narrow
                        lx0 <= cx - xa;
                        lx1 <= cx + xa;
                        ly  <= cy - ya;
                    end
                    2'd2: begin  // lower row, wide
                        lx0 <= cx - ya;
                        lx1 <= cx + ya;
                        ly  <= cy + xa;
                    end
                    default: begin  // upper row, wide
                        lx0 <= cx - ya;
                        lx1 <= cx + ya;
                        ly  <= cy - xa;
                    end
                endcase
            end
            WAIT: if (ldone) span_id <= span_id + 2'd1;
            STEP: begin
                xa <= xa + coord_t'(1);
                if (err < 0) begin  // midpoint inside, keep y
                    err <= err + (err_t'(xa) <<< 1) + err_t'(3);
                end else begin      // midpoint outside, step y in
                    err <= err + ((err_t'(xa) - err_t'(ya)) <<< 1) + err_t'(5);
                    ya  <= ya - coord_t'(1);
                end
            end
            default: ;
        endcase
    end

    // oe only stalls the pixel stream inside the span drawer
    draw_line_1d u_line (
        .clk     (clk),
        .rst     (rst),
        .start   (lstart),
        .oe      (oe),
        .lx0     (lx0),
        .lx1     (lx1),
        .ly      (ly),
        .x       (x),
        .y       (y),
        .drawing (drawing),
        .done    (ldone)
    );

endmodule

`default_nettype wire

/* hdl/draw_line_1d.sv */
// horizontal span drawer
// steps x from lx0 to lx1 on row ly, one pixel per enabled cycle
`default_nettype none

module draw_line_1d import draw_pkg::*; (
    input  wire logic   clk,      // clock
    input  wire logic   rst,      // sync reset
    input  wire logic   start,    // begin span, lx0/lx1/ly valid
    input  wire logic   oe,       // output enable, low stalls
    input  wire coord_t lx0,      // left end
    input  wire coord_t lx1,      // right end
    input  wire coord_t ly,       // row
    output coord_t      x,        // current pixel column
    output coord_t      y,        // current pixel row
    output logic        drawing,  // x/y hold a pixel
    output logic        done      // span finished, one cycle
);

    coord_t x_end;  // latched right end

    // span ends and row
    always_ff @(posedge clk) begin
        if (start) begin
            x     <= lx0;
            y     <= ly;
            x_end <= lx1;
        end else if (drawing && oe && x != x_end) begin
            x <= x + coord_t'(1);  // next pixel along the row
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drawing <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                drawing <= (lx0 <= lx1);  // empty span draws nothing
                done    <= (lx0 > lx1);   // but still reports back
            end else if (drawing && oe && x == x_end) begin
                drawing <= 1'b0;  // right end just presented
                done    <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fb_pkg.sv */
// framebuffer package
// canvas size and address type for the colour-index framebuffer
`default_nettype none

package fb_pkg;

    localparam int FB_WIDTH = 320;   // canvas width in pixels
    localparam int FB_HEIGHT = 180;  // canvas height in pixels
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // memory depth
    localparam int FB_ADDRW = 16;    // enough for FB_PIXELS

    // linear pixel address, row major
    typedef logic [FB_ADDRW-1:0] fb_addr_t;

endpackage

`default_nettype wire

/* hdl/draw_pkg.sv */
// drawing package
// coordinate and colour index types for the shape drawers
`default_nettype none

package draw_pkg;

    localparam int CORDW = 16;     // signed coordinate width
    localparam int CIDXW = 4;      // colour index width
    localparam int SHAPE_CNT = 8;  // circles in the rainbow

    // screen coordinate, signed so shapes may run off the canvas
    typedef logic signed [CORDW-1:0] coord_t;

    // index into an external palette
    typedef logic [CIDXW-1:0] cidx_t;

endpackage

`default_nettype wire
